//--- include/riscv_consts.svh
`ifndef riscv_consts_svh
`define riscv_consts_svh

// address map
`define ram_base        64'h0000_0000_0000_1000 // main program start, pc after reset
`define key_base        64'h0000_0000_2000_0000 // key port, read only
`define art_base        64'h0000_0000_2000_0008 // art port, write only
`define isr_base        64'h0000_0000_0000_0000 // fixed handler entry, no mtvec

// custom instruction words, matched exactly by the core
`define instr_lb_key    32'hffff_ffff // x5 <= key code
`define instr_sb_art    32'hffff_ff7f // art port <= x5, rd field 11110
`define instr_mret      32'h0000_0000 // return from handler
`define instr_nop       32'h0000_0013 // addi x0,x0,0, no effect on this core

// machine external interrupt: interrupt bit plus cause 11
`define mcause_mei      64'h8000_0000_0000_000b

// program store layout, main region first in the image
`define rom_main_words  8
`define rom_isr_words   4

`endif

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

    parameter int xlen = 64; // register width
    parameter int ilen = 32; // instruction width

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [ilen-1:0] instr_t;
    typedef logic [4:0]      reg_idx_t;   // x0..x31
    typedef logic [11:0]     csr_idx_t;   // csr address space

    // major opcodes, bits 6:0 of the word
    typedef enum logic [6:0] {
        op_system = 7'b1110011,
        op_lui    = 7'b0110111,
        op_custom = 7'b1111111  // all-ones space, used by the key and art words
    } opcode_t;

    // machine csrs implemented by the core
    localparam csr_idx_t csr_mstatus = 12'h300;
    localparam csr_idx_t csr_mepc    = 12'h341;
    localparam csr_idx_t csr_mcause  = 12'h342;

    // mstatus fields
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

endpackage

//--- source/soc_bus_pkg.sv
package soc_bus_pkg;

    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;

    // interrupt lines into the core, one code per source
    typedef logic [3:0]  irq_vector_t;

    // key press payload, also what the art port shows
    typedef logic [7:0]  key_code_t;

    localparam irq_vector_t irq_none = 4'd0;
    localparam irq_vector_t irq_mei  = 4'd1; // key port, machine external

endpackage

//--- source/riscv64.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module riscv64 (
    input  logic                      clk,
    input  logic                      reset,            // active low, async
    input  rv_isa_pkg::instr_t        instruction,      // rom word at pc
    output rv_isa_pkg::xlen_t         pc,
    output logic                      heartbeat,
    input  soc_bus_pkg::irq_vector_t  interrupt_vector, // level from key port
    output logic                      interrupt_ack,    // one cycle after entry
    output soc_bus_pkg::bus_addr_t    bus_address,
    output soc_bus_pkg::bus_data_t    bus_write_data,
    output logic                      bus_write_enable,
    output logic                      bus_read_enable,
    input  soc_bus_pkg::bus_data_t    bus_read_data     // registered by the slave
);

    localparam rv_isa_pkg::reg_idx_t key_reg = 5'd5; // fixed target of the key words
    localparam rv_isa_pkg::xlen_t mstatus_reset = 64'h8; // only mie set

    rv_isa_pkg::instr_t   ir;             // fetch register
    rv_isa_pkg::xlen_t    gpr [0:31];
    rv_isa_pkg::xlen_t    mstatus;
    rv_isa_pkg::xlen_t    mepc;
    rv_isa_pkg::xlen_t    mcause;
    logic                 bubble;         // kill the word fetched before a redirect
    logic                 lb_step;        // second half of the key load

    rv_isa_pkg::opcode_t  opcode;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::xlen_t    imm_u;
    rv_isa_pkg::xlen_t    mstatus_rd;
    rv_isa_pkg::xlen_t    mret_pc;
    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    logic                 take_irq;
    logic                 exec;           // ir is live this cycle

    logic                 gpr_we;
    rv_isa_pkg::reg_idx_t gpr_waddr;
    rv_isa_pkg::xlen_t    gpr_wdata;

    // csr address decode, read side
    function automatic rv_isa_pkg::xlen_t csr_read(input rv_isa_pkg::csr_idx_t idx);
        case (idx)
            rv_isa_pkg::csr_mstatus: csr_read = mstatus;
            rv_isa_pkg::csr_mepc:    csr_read = mepc;
            rv_isa_pkg::csr_mcause:  csr_read = mcause;
            default:                 csr_read = '0; // unimplemented reads as zero
        endcase
    endfunction

    assign opcode = rv_isa_pkg::opcode_t'(ir[6:0]);
    assign rd     = ir[11:7];
    assign imm_u  = {{32{ir[31]}}, ir[31:12], 12'h000}; // sign extended upper imm

    assign mstatus_rd   = csr_read(rv_isa_pkg::csr_mstatus);
    assign mret_pc      = csr_read(rv_isa_pkg::csr_mepc);
    assign mstatus_mie  = mstatus_rd[rv_isa_pkg::mstatus_mie_bit];
    assign mstatus_mpie = mstatus_rd[rv_isa_pkg::mstatus_mpie_bit];

    // no entry on a bubble, the pc there is not a resumable point
    assign take_irq = (interrupt_vector == soc_bus_pkg::irq_mei) && mstatus_mie && !bubble;
    assign exec     = !take_irq && !bubble;

    // register file write port
    always_comb begin
        gpr_we    = 1'b0;
        gpr_waddr = rd;
        gpr_wdata = imm_u;
        if (exec) begin
            if (opcode == rv_isa_pkg::op_lui) begin
                gpr_we = (rd != '0); // x0 stays zero
            end else if (ir == `instr_lb_key && lb_step) begin
                gpr_we    = 1'b1;
                gpr_waddr = key_reg;
                gpr_wdata = bus_read_data; // zero extended code from key port
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gpr_we)
            gpr[gpr_waddr] <= gpr_wdata;
    end

    // fetch, one word per cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= `instr_nop;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat; // liveness toggle
        end
    end

    // execute
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc               <= `ram_base;
            bubble           <= 1'b0;
            lb_step          <= 1'b0;
            interrupt_ack    <= 1'b0;
            bus_address      <= '0;
            bus_write_data   <= '0;
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
            mstatus          <= mstatus_reset;
            mepc             <= '0;
            mcause           <= '0;
        end else begin
            pc            <= pc + 64'd4; // sequential unless redirected below
            interrupt_ack <= 1'b0;

            if (take_irq) begin
                mepc          <= pc;            // word in fetch resumes after mret
                mcause        <= `mcause_mei;
                mstatus[rv_isa_pkg::mstatus_mpie_bit] <= mstatus_mie;
                mstatus[rv_isa_pkg::mstatus_mie_bit]  <= 1'b0;  // no nesting
                pc            <= `isr_base;
                bubble        <= 1'b1;
                interrupt_ack <= 1'b1;
            end else if (bubble) begin
                bubble <= 1'b0; // ir discarded, bus strobes held
            end else begin
                bus_address      <= '0;
                bus_write_data   <= '0;
                bus_write_enable <= 1'b0;
                bus_read_enable  <= 1'b0;

                if (ir == `instr_mret) begin
                    mstatus[rv_isa_pkg::mstatus_mie_bit]  <= mstatus_mpie;
                    mstatus[rv_isa_pkg::mstatus_mpie_bit] <= 1'b1;
                    pc     <= mret_pc;
                    bubble <= 1'b1;
                end else if (ir == `instr_lb_key) begin
                    if (!lb_step) begin
                        // step 0: issue read, refetch this word, wait out the slave
                        bus_address     <= `key_base;
                        bus_read_enable <= 1'b1;
                        pc              <= pc - 64'd4;
                        bubble          <= 1'b1;
                        lb_step         <= 1'b1;
                    end else begin
                        lb_step <= 1'b0; // step 1, x5 written by the port above
                    end
                end else if (ir == `instr_sb_art) begin
                    bus_address      <= `art_base;
                    bus_write_data   <= gpr[key_reg];
                    bus_write_enable <= 1'b1; // single cycle strobe
                end
            end
        end
    end

endmodule

//--- source/instr_rom.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module instr_rom (
    input  rv_isa_pkg::xlen_t  pc,
    output rv_isa_pkg::instr_t instruction
);

    localparam int image_words = `rom_main_words + `rom_isr_words;
    localparam int main_aw     = $clog2(`rom_main_words);
    localparam int isr_aw      = $clog2(`rom_isr_words);

    rv_isa_pkg::instr_t image      [0:image_words-1];     // whole hex file
    rv_isa_pkg::instr_t main_words [0:`rom_main_words-1];
    rv_isa_pkg::instr_t isr_words  [0:`rom_isr_words-1];
    rv_isa_pkg::xlen_t  main_offset;
    rv_isa_pkg::xlen_t  isr_offset;

    initial begin
        $readmemh("instr_rom.hex", image);
    end

    // split the image, main program first then handler
    for (genvar i = 0; i < `rom_main_words; i++) begin : g_main
        assign main_words[i] = image[i];
    end
    for (genvar j = 0; j < `rom_isr_words; j++) begin : g_isr
        assign isr_words[j] = image[`rom_main_words + j];
    end

    assign main_offset = (pc - `ram_base) >> 2; // word index within region
    assign isr_offset  = (pc - `isr_base) >> 2;

    always_comb begin
        instruction = `instr_nop; // past the end of either program
        if (pc < `ram_base) begin
            if (isr_offset < rv_isa_pkg::xlen_t'(`rom_isr_words))
                instruction = isr_words[isr_offset[isr_aw-1:0]];
        end else if (main_offset < rv_isa_pkg::xlen_t'(`rom_main_words)) begin
            instruction = main_words[main_offset[main_aw-1:0]];
        end
    end

endmodule

//--- source/key_port.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module key_port (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      key_strobe,      // one cycle per press
    input  soc_bus_pkg::key_code_t    key_code,        // valid with the strobe
    input  logic                      interrupt_ack,
    input  soc_bus_pkg::bus_addr_t    bus_address,
    input  logic                      bus_read_enable,
    output soc_bus_pkg::bus_data_t    bus_read_data,
    output soc_bus_pkg::irq_vector_t  interrupt_vector
);

    soc_bus_pkg::key_code_t key_latch;
    logic                   pending;

    // pending flag, a fresh strobe beats a same-cycle ack
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pending <= 1'b0;
        end else if (key_strobe) begin
            pending <= 1'b1;
        end else if (interrupt_ack) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (key_strobe)
            key_latch <= key_code; // latest press wins
    end

    // read data one cycle after the enable
    always_ff @(posedge clk) begin
        if (bus_read_enable && bus_address == `key_base)
            bus_read_data <= {56'b0, key_latch};
    end

    assign interrupt_vector = pending ? soc_bus_pkg::irq_mei : soc_bus_pkg::irq_none;

endmodule

//--- source/art_port.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module art_port (
    input  logic                    clk,
    input  logic                    reset,
    input  soc_bus_pkg::bus_addr_t  bus_address,
    input  soc_bus_pkg::bus_data_t  bus_write_data,
    input  logic                    bus_write_enable,
    output soc_bus_pkg::key_code_t  art_data,
    output logic                    art_valid    // pulse, cycle after the write
);

    logic art_hit;

    assign art_hit = bus_write_enable && (bus_address == `art_base); // other addresses dropped

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_valid <= 1'b0;
        end else begin
            art_valid <= art_hit;
        end
    end

    // only the low byte is meaningful
    always_ff @(posedge clk) begin
        if (art_hit)
            art_data <= bus_write_data[7:0];
    end

endmodule

//--- source/riscv_soc.sv
`timescale 1ns/1ns

module riscv_soc (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    key_strobe,
    input  soc_bus_pkg::key_code_t  key_code,
    output soc_bus_pkg::key_code_t  art_data,
    output logic                    art_valid,
    output rv_isa_pkg::xlen_t       pc,
    output logic                    heartbeat
);

    rv_isa_pkg::instr_t        instruction;
    soc_bus_pkg::irq_vector_t  interrupt_vector;
    logic                      interrupt_ack;
    soc_bus_pkg::bus_addr_t    bus_address;
    soc_bus_pkg::bus_data_t    bus_write_data;
    soc_bus_pkg::bus_data_t    bus_read_data;   // key port is the only reader
    logic                      bus_write_enable;
    logic                      bus_read_enable;

    riscv64 core0 (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    instr_rom rom0 (
        .pc          (pc),
        .instruction (instruction)
    );

    key_port key0 (
        .clk              (clk),
        .reset            (reset),
        .key_strobe       (key_strobe),
        .key_code         (key_code),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector)
    );

    art_port art0 (
        .clk              (clk),
        .reset            (reset),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .art_data         (art_data),
        .art_valid        (art_valid)
    );

endmodule

//--- sim/tb_riscv_soc.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module tb_riscv_soc;

    localparam int num_keys       = 40;
    localparam int timeout_cycles = 200; // per wait

    logic                   clk;
    logic                   reset;
    logic                   key_strobe;
    soc_bus_pkg::key_code_t key_code;
    soc_bus_pkg::key_code_t art_data;
    logic                   art_valid;
    rv_isa_pkg::xlen_t      pc;
    logic                   heartbeat;

    soc_bus_pkg::key_code_t expected_codes [$]; // presses not yet echoed
    soc_bus_pkg::key_code_t popped_code;
    rv_isa_pkg::xlen_t      expected_pc;        // main flow before any press
    rv_isa_pkg::xlen_t      last_main_pc;       // last sample at or above ram_base
    rv_isa_pkg::xlen_t      saved_pc;           // where the handler must return to
    int   test_checks [1:5];
    int   test_errors [1:5];
    int   presses;
    int   echoes;
    bit   monitor_on;
    bit   pressed_any;
    bit   in_isr;      // pc seen below ram_base with no return yet
    bit   echo_seen;   // art_valid seen since handler entry
    logic expected_hb; // low out of reset, then one toggle per cycle
    bit   timed_out;

    riscv_soc dut0 (
        .clk        (clk),
        .reset      (reset),
        .key_strobe (key_strobe),
        .key_code   (key_code),
        .art_data   (art_data),
        .art_valid  (art_valid),
        .pc         (pc),
        .heartbeat  (heartbeat)
    );

    always #5 clk = ~clk; // 10 ns period

    task automatic check_hex(input int test_id, input string name,
                             input logic [63:0] expected, input logic [63:0] actual);
        test_checks[test_id]++;
        assert (actual === expected) else begin
            $display("Fail %s expected 0x%0h actual 0x%0h (test %0d, %0t)",
                     name, expected, actual, test_id, $time);
            test_errors[test_id]++;
        end
    endtask

    task automatic check_true(input int test_id, input bit cond, input string what);
        test_checks[test_id]++;
        assert (cond) else begin
            $display("Error in test %0d at %0t: %s", test_id, $time, what);
            test_errors[test_id]++;
        end
    endtask

    task automatic report_test(input int test_id, input string name);
        $display("test %0d %s: %0d checks, %0d errors",
                 test_id, name, test_checks[test_id], test_errors[test_id]);
    endtask

    // one-cycle strobe driven just after the edge
    task automatic press_key(input soc_bus_pkg::key_code_t code);
        @(posedge clk);
        #1;
        key_strobe = 1'b1;
        key_code   = code;
        expected_codes.push_back(code);
        presses++;
        pressed_any = 1'b1;
        @(posedge clk);
        #1;
        key_strobe = 1'b0;
    endtask

    task automatic wait_echo();
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            seen = art_valid;
        end
        check_true(4, seen, "no art_valid echo within the timeout after a key press");
        timed_out = !seen;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (monitor_on) begin
            check_hex(2, "heartbeat", {63'd0, expected_hb}, {63'd0, heartbeat});
            expected_hb = ~expected_hb;

            if (!pressed_any) begin
                check_hex(3, "pc", expected_pc, pc); // straight line fetch
                expected_pc = expected_pc + 64'd4;
            end

            if (art_valid) begin
                echo_seen = 1'b1;
                if (expected_codes.size() == 0) begin
                    check_true(4, 1'b0, "art_valid pulse without a preceding key press");
                end else begin
                    popped_code = expected_codes.pop_front();
                    check_hex(4, "art_data", {56'd0, popped_code}, {56'd0, art_data});
                    echoes++;
                end
            end

            if (pc < `ram_base) begin
                if (!in_isr) begin
                    in_isr    = 1'b1;
                    saved_pc  = last_main_pc; // mepc should hold this
                    echo_seen = 1'b0;
                end
                check_true(5, presses > echoes, "pc below ram_base with no key press outstanding");
            end else begin
                if (in_isr) begin
                    check_true(5, echo_seen, "handler returned before the echo");
                    check_hex(5, "pc", saved_pc, pc);
                    in_isr = 1'b0;
                end
                last_main_pc = pc;
            end
        end
    end

    initial begin
        int idle;
        int total_checks;
        int total_errors;
        soc_bus_pkg::key_code_t code;
        clk         = 1'b0;
        reset       = 1'b0;
        key_strobe  = 1'b0;
        key_code    = '0;
        monitor_on  = 1'b0;
        pressed_any = 1'b0;
        in_isr      = 1'b0;
        echo_seen   = 1'b0;
        expected_hb = 1'b0;
        timed_out   = 1'b0;
        presses     = 0;
        echoes      = 0;
        expected_pc = `ram_base;
        last_main_pc = `ram_base;
        saved_pc    = `ram_base;
        for (int t = 1; t <= 5; t++) begin
            test_checks[t] = 0;
            test_errors[t] = 0;
        end
        void'($urandom(79));

        repeat (3) begin
            @(negedge clk);
            check_hex(1, "art_valid", 64'd0, {63'd0, art_valid}); // quiet under reset
        end
        @(posedge clk);
        #1;
        reset      = 1'b1;
        monitor_on = 1'b1;
        @(negedge clk);
        check_hex(1, "pc", `ram_base, pc);
        check_hex(1, "art_valid", 64'd0, {63'd0, art_valid});
        report_test(1, "reset state");

        for (int i = 0; i < num_keys && !timed_out; i++) begin
            idle = $urandom_range(15, 0);
            repeat (idle) @(posedge clk);
            code = soc_bus_pkg::key_code_t'($urandom);
            press_key(code);
            if (i == 0)
                report_test(3, "main program flow");
            wait_echo();
        end
        if (!timed_out)
            repeat (20) @(negedge clk); // tail to catch stray pulses

        check_true(4, presses == echoes && expected_codes.size() == 0,
                   "key presses left without an echo");
        check_true(5, !in_isr, "pc still in the handler at the end");
        report_test(2, "heartbeat");
        report_test(4, "echo");
        report_test(5, "return address");

        total_checks = 0;
        total_errors = 0;
        for (int t = 1; t <= 5; t++) begin
            total_checks += test_checks[t];
            total_errors += test_errors[t];
        end
        $display("presses %0d, echoes %0d, checks %0d, errors %0d",
                 presses, echoes, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- instr_rom.hex
// one 32-bit instruction word per line, in hex
// words 0-7 main program at ram_base, words 8-11 handler at address zero
123450b7 // lui x1, 0x12345
00000013 // nop
abcde137 // lui x2, 0xabcde
00000013 // nop
000011b7 // lui x3, 0x1
00000013 // nop
00000013 // nop
00000013 // nop, falls through to the rom fill
ffffffff // handler: load key code into x5
ffffff7f // store x5 to the art port
00000000 // mret
00000013 // nop, never executed

//--- all.f
+incdir+include
source/rv_isa_pkg.sv
source/soc_bus_pkg.sv
source/riscv64.sv
source/instr_rom.sv
source/key_port.sv
source/art_port.sv
source/riscv_soc.sv
sim/tb_riscv_soc.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_riscv_soc -f all.f

# the rom image is read relative to the project root
out=$(./obj_dir/Vtb_riscv_soc)
echo "$out"

# a missing pass line makes grep, and so the script, fail
echo "$out" | grep -qx "sim passed"
